// ==== rtl/isaPkg.sv ====
// Instruction set definitions
package isaPkg;

   // Field positions inside the 16-bit instruction word
   localparam int OPCODE_MSB = 15;
   localparam int OPCODE_LSB = 11;
   localparam int RS_MSB     = 10;  // First source register, also the branch operand
   localparam int RS_LSB     = 8;
   localparam int RT_MSB     = 7;   // Second source register
   localparam int RT_LSB     = 5;

   localparam int OPCODE_W = OPCODE_MSB - OPCODE_LSB + 1;  // Major opcode is five bits wide
   localparam int COND_W   = 2;  // Low opcode bits that pick the branch condition

   // The top three opcode bits mark a conditional branch when they equal this value
   localparam logic [2:0] BRANCH_GROUP = 3'b011;

   // Major opcodes that matter to the decode stage
   // Anything else is folded into opOther before it reaches the helper blocks
   typedef enum logic [OPCODE_W-1:0] {
      opOther = 5'b00000,  // Catch-all class for opcodes decode does not act on
      opJ     = 5'b00100,  // PC relative jump
      opJr    = 5'b00101,  // Register jump
      opJal   = 5'b00110,  // PC relative jump and link
      opJalr  = 5'b00111,  // Register jump and link
      opBeqz  = 5'b01100,  // Branch when Rs equals zero
      opBnez  = 5'b01101,  // Branch when Rs is not zero
      opBltz  = 5'b01110,  // Branch when Rs is negative
      opBgez  = 5'b01111   // Branch when Rs is zero or positive
   } opcodeT;

   // Branch condition carried in the two low opcode bits
   // The encoding lines up with the low bits of the four branch opcodes
   typedef enum logic [COND_W-1:0] {
      condEqz = 2'b00,  // Rs == 0
      condNez = 2'b01,  // Rs != 0
      condLtz = 2'b10,  // Rs < 0, sign bit set
      condGez = 2'b11   // Rs >= 0, sign bit clear
   } branchCondT;

   // Both link jumps share this pair of opcodes
   // A live one in decode writes r7 straight away
   // Its writeback three cycles later is then dropped

endpackage

// ==== rtl/datapathPkg.sv ====
// Datapath sizes and write sources
package datapathPkg;

   localparam int DATA_W = 16;  // Word width of registers, PC and immediates

   // Register file geometry
   localparam int REG_COUNT  = 8;
   localparam int REG_ADDR_W = $clog2(REG_COUNT);  // Three address bits for eight registers

   // Jump and link always returns through r7
   localparam logic [REG_ADDR_W-1:0] LINK_REG = 3'd7;

   // Instructions are two bytes, so the return address is the PC plus two
   localparam logic [DATA_W-1:0] PC_STEP = 16'd2;

   // Where the register file write data comes from
   typedef enum logic [1:0] {
      srcWriteback = 2'b00,  // Result handed back by the last pipeline stage
      srcImm       = 2'b01,  // LBI immediate
      srcLink      = 2'b10   // Return address, current PC plus two
   } wrSrcT;

   // The link tracker settles the source each cycle
   // The stage top turns it into the actual data word

endpackage

// ==== rtl/regPortIf.sv ====
// Register file port bundle
interface regPortIf
   import datapathPkg::*;
();

   // Two combinational read ports
   logic [REG_ADDR_W-1:0] rdAddr1;  // Rs
   logic [REG_ADDR_W-1:0] rdAddr2;  // Rt
   logic [DATA_W-1:0]     rdData1;
   logic [DATA_W-1:0]     rdData2;

   // Single clocked write port
   logic                  wrEn;
   logic [REG_ADDR_W-1:0] wrAddr;
   logic [DATA_W-1:0]     wrData;

   // Decode side sets up the addresses and the write, takes back the read data
   modport stage (
      output rdAddr1, rdAddr2,
      output wrEn, wrAddr, wrData,
      input  rdData1, rdData2
   );

   // Storage side answers reads and performs the write
   modport store (
      input  rdAddr1, rdAddr2,
      input  wrEn, wrAddr, wrData,
      output rdData1, rdData2
   );

endinterface

// ==== rtl/regFile.sv ====
// Eight entry register file
module regFile
   import datapathPkg::*;
(
   input logic     clk,
   input logic     rstN,
   regPortIf.store port
);

   logic [DATA_W-1:0] regs [REG_COUNT];  // Architectural registers r0 to r7

   // Read one register, forwarding the write that lands on the coming edge
   // This way a reader in the same cycle as the writer already sees the new value
   function automatic logic [DATA_W-1:0] readBypass(input logic [REG_ADDR_W-1:0] addr);
      logic hit;
      hit = port.wrEn && (port.wrAddr == addr);
      if (hit) begin
         return port.wrData;  // Write-through path
      end
      return regs[addr];
   endfunction

   // Both read ports are purely combinational
   always_comb begin
      port.rdData1 = readBypass(port.rdAddr1);
      port.rdData2 = readBypass(port.rdAddr2);  // Same rule as port 1
   end

   // One write per cycle at the rising edge
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         // Every register starts at zero
         for (int i = 0; i < REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (port.wrEn) begin
         regs[port.wrAddr] <= port.wrData;  // Address and data come already resolved
      end
   end

   // r0 is an ordinary register in this ISA and can be written
   // The link tracker picks the address, so this block never checks it

endmodule

// ==== rtl/branchResolve.sv ====
// Branch and jump resolution
module branchResolve
   import isaPkg::*;
   import datapathPkg::*;
(
   input  opcodeT            opcode,   // Already classified by the stage top
   input  logic [DATA_W-1:0] rsValue,  // Rs as read this cycle, write-through included
   input  logic              halt,
   output logic              pcSel     // High to redirect fetch
);

   logic       isZero;    // Rs is all zeros
   logic       isNeg;     // Sign bit of Rs
   logic       isBranch;  // One of the four conditional branches
   logic       isJump;    // One of the four unconditional jumps
   logic       condMet;   // Branch condition holds for Rs
   branchCondT cond;

   // Flags on the single operand
   assign isZero = (rsValue == '0);
   assign isNeg  = rsValue[DATA_W-1];  // Two's complement sign

   // The top three opcode bits tell a branch apart from everything else
   assign isBranch = (opcode[OPCODE_W-1 -: 3] == BRANCH_GROUP);
   assign cond     = branchCondT'(opcode[COND_W-1:0]);  // Low bits name the condition

   // Condition test
   always_comb begin
      case (cond)
         condEqz: condMet = isZero;
         condNez: condMet = !isZero;
         condLtz: condMet = isNeg;
         condGez: condMet = !isNeg;  // Zero counts as non-negative
         default: condMet = 1'b0;
      endcase
   end

   // Jumps always redirect, linked or not
   always_comb begin
      case (opcode)
         opJ, opJr, opJal, opJalr: isJump = 1'b1;
         default:                  isJump = 1'b0;
      endcase
   end

   // A halted pipeline never redirects the PC
   assign pcSel = !halt && ((isBranch && condMet) || isJump);

endmodule

// ==== rtl/linkTracker.sv ====
// Jump and link write tracking
module linkTracker
   import isaPkg::*;
   import datapathPkg::*;
(
   input  logic                  clk,
   input  logic                  rstN,
   input  opcodeT                opcode,  // Opcode class of the instruction in decode
   input  logic                  halt,
   input  logic                  wbEn,    // Write request from the last stage
   input  logic [REG_ADDR_W-1:0] wbAddr,
   input  logic                  lbi,     // Writeback carries an LBI immediate
   input  logic                  link,    // Writeback carries a return address
   output logic                  wrEn,
   output logic [REG_ADDR_W-1:0] wrAddr,
   output wrSrcT                 wrSrc
);

   logic jalDecode;  // Live jump and link sitting in decode
   logic jalEx;      // Same instruction one stage on, in execute
   logic jalMem;     // In memory
   logic jalWb;      // In writeback, where its late write must be dropped

   // A halted jump and link does not retire, so it neither writes nor enters the shadow
   always_comb begin
      jalDecode = ((opcode == opJal) || (opcode == opJalr)) && !halt;
   end

   // Shadow of the link instruction as it moves down the pipeline
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         jalEx  <= 1'b0;
         jalMem <= 1'b0;
         jalWb  <= 1'b0;
      end else begin
         jalEx  <= jalDecode;
         jalMem <= jalEx;
         jalWb  <= jalMem;  // Lines up with wbEn from the real pipeline
      end
   end

   // Decode-time r7 write always goes through
   // The late write of the same instruction has already happened, so it is masked
   assign wrEn = jalDecode || (wbEn && !jalWb);

   // Link write in decode owns the port, otherwise the writeback address is used
   assign wrAddr = jalDecode ? LINK_REG : wbAddr;

   // Data source by priority
   always_comb begin
      if (jalDecode) begin
         wrSrc = srcLink;  // Return address of the instruction in decode
      end else if (link) begin
         wrSrc = srcLink;  // Writeback asks for the return address, link beats lbi
      end else if (lbi) begin
         wrSrc = srcImm;
      end else begin
         wrSrc = srcWriteback;
      end
   end

endmodule

// ==== rtl/decodeStage.sv ====
// Processor decode stage
module decodeStage
   import isaPkg::*;
   import datapathPkg::*;
(
   input  logic                  clk,
   input  logic                  rstN,
   input  logic [DATA_W-1:0]     instr,      // Instruction in decode
   input  logic [DATA_W-1:0]     imm,        // LBI immediate from the writeback side
   input  logic [DATA_W-1:0]     writeback,  // Result from the last stage
   input  logic [DATA_W-1:0]     pcNow,      // PC used for the return address
   input  logic [REG_ADDR_W-1:0] wbAddr,     // Destination of the writeback
   input  logic                  wbEn,
   input  logic                  lbi,
   input  logic                  link,
   input  logic                  halt,
   output logic [DATA_W-1:0]     reg1Data,   // Rs contents
   output logic [DATA_W-1:0]     reg2Data,   // Rt contents
   output logic                  pcSel       // Taken branch or jump
);

   opcodeT            opcode;     // Classified major opcode
   logic [DATA_W-1:0] linkValue;  // Return address, pcNow plus one instruction
   wrSrcT             wrSrc;      // Chosen by the link tracker

   regPortIf regPort ();  // Bundle between this stage and the register file

   // Fold the raw opcode into the classes the helper blocks know about
   always_comb begin
      case (instr[OPCODE_MSB:OPCODE_LSB])
         opJ, opJr, opJal, opJalr,
         opBeqz, opBnez, opBltz, opBgez: begin
            opcode = opcodeT'(instr[OPCODE_MSB:OPCODE_LSB]);
         end
         default: begin
            opcode = opOther;  // ALU, memory and system opcodes look alike here
         end
      endcase
   end

   // Register fields go straight to the read ports
   assign regPort.rdAddr1 = instr[RS_MSB:RS_LSB];
   assign regPort.rdAddr2 = instr[RT_MSB:RT_LSB];

   assign linkValue = pcNow + PC_STEP;  // Wraps at the top of the address space

   // Turn the source choice into the data word
   always_comb begin
      case (wrSrc)
         srcLink: regPort.wrData = linkValue;
         srcImm:  regPort.wrData = imm;
         default: regPort.wrData = writeback;
      endcase
   end

   // Storage with write-through reads
   regFile regFile0 (
      .clk  (clk),
      .rstN (rstN),
      .port (regPort.store)
   );

   // Owns the write enable and address, including the r7 link write
   linkTracker linkTracker0 (
      .clk    (clk),
      .rstN   (rstN),
      .opcode (opcode),
      .halt   (halt),
      .wbEn   (wbEn),
      .wbAddr (wbAddr),
      .lbi    (lbi),
      .link   (link),
      .wrEn   (regPort.wrEn),
      .wrAddr (regPort.wrAddr),
      .wrSrc  (wrSrc)
   );

   // Branch operand is Rs as seen on read port 1
   branchResolve branchResolve0 (
      .opcode  (opcode),
      .rsValue (regPort.rdData1),
      .halt    (halt),
      .pcSel   (pcSel)
   );

   // Read data leaves the stage unchanged
   assign reg1Data = regPort.rdData1;
   assign reg2Data = regPort.rdData2;

endmodule

// ==== tb/tbClock.sv ====
// Testbench clock and reset
module tbClock (
   output logic clk,
   output logic rstN
);

   // Free running clock with a period of four time units
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Reset is held low for ten full cycles
   initial begin
      rstN = 1'b0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rstN = 1'b1;  // Released away from the active edge
   end

endmodule

// ==== tb/decodeStageTb.sv ====
// Decode stage testbench
module decodeStageTb
   import isaPkg::*;
   import datapathPkg::*;
();

   localparam logic [OPCODE_W-1:0] OP_ALU = 5'b11011;  // Plain ALU opcode, neither branch nor jump

   logic                  clk;
   logic                  rstN;
   logic [DATA_W-1:0]     instr;
   logic [DATA_W-1:0]     imm;
   logic [DATA_W-1:0]     writeback;
   logic [DATA_W-1:0]     pcNow;
   logic [REG_ADDR_W-1:0] wbAddr;
   logic                  wbEn;
   logic                  lbi;
   logic                  link;
   logic                  halt;
   logic [DATA_W-1:0]     reg1Data;
   logic [DATA_W-1:0]     reg2Data;
   logic                  pcSel;

   logic [DATA_W-1:0] model [REG_COUNT];  // Reference copy of the register file
   logic [2:0]        shadow;             // Link jump positions, bit 0 execute up to bit 2 writeback
   logic [31:0]       rngState;
   int                checks;
   int                errors;

   tbClock clock0 (
      .clk  (clk),
      .rstN (rstN)
   );

   decodeStage dut0 (
      .clk       (clk),
      .rstN      (rstN),
      .instr     (instr),
      .imm       (imm),
      .writeback (writeback),
      .pcNow     (pcNow),
      .wbAddr    (wbAddr),
      .wbEn      (wbEn),
      .lbi       (lbi),
      .link      (link),
      .halt      (halt),
      .reg1Data  (reg1Data),
      .reg2Data  (reg2Data),
      .pcSel     (pcSel)
   );

   // Xorshift32 generator
   function automatic logic [31:0] nextRandom();
      rngState = rngState ^ (rngState << 13);
      rngState = rngState ^ (rngState >> 17);
      rngState = rngState ^ (rngState << 5);
      return rngState;
   endfunction

   function automatic logic [DATA_W-1:0] rand16();
      logic [31:0] r;
      r = nextRandom();
      return r[15:0];
   endfunction

   function automatic logic [REG_ADDR_W-1:0] rand3();
      logic [31:0] r;
      r = nextRandom();
      return r[10:8];  // Middle bits mix better than the lowest ones
   endfunction

   // Builds an instruction word from opcode and register fields
   function automatic logic [DATA_W-1:0] makeInstr(input logic [OPCODE_W-1:0] op,
                                                   input logic [REG_ADDR_W-1:0] rs,
                                                   input logic [REG_ADDR_W-1:0] rt);
      logic [DATA_W-1:0] word;
      word = '0;
      word[OPCODE_MSB:OPCODE_LSB] = op;
      word[RS_MSB:RS_LSB] = rs;
      word[RT_MSB:RT_LSB] = rt;
      return word;
   endfunction

   // A live jump and link in decode, which a halt cancels
   function automatic logic isLinkJump();
      logic [OPCODE_W-1:0] op;
      op = instr[OPCODE_MSB:OPCODE_LSB];
      return ((op == opJal) || (op == opJalr)) && !halt;
   endfunction

   // The write the stage should perform at the coming edge
   function automatic void plannedWrite(output logic en, output logic [REG_ADDR_W-1:0] addr,
                                        output logic [DATA_W-1:0] data);
      if (isLinkJump()) begin
         en = 1'b1;  // Decode-time link write always wins
         addr = LINK_REG;
         data = pcNow + PC_STEP;
      end else begin
         en = wbEn && !shadow[2];  // Late writeback of the same link jump is dropped
         addr = wbAddr;
         if (link) begin
            data = pcNow + PC_STEP;
         end else if (lbi) begin
            data = imm;
         end else begin
            data = writeback;
         end
      end
   endfunction

   // Read value including write-through
   function automatic logic [DATA_W-1:0] expectRead(input logic [REG_ADDR_W-1:0] addr);
      logic                  en;
      logic [REG_ADDR_W-1:0] wa;
      logic [DATA_W-1:0]     wd;
      plannedWrite(en, wa, wd);
      if (en && (wa == addr)) begin
         return wd;
      end
      return model[addr];
   endfunction

   // Branch taken on the zero and sign rule, jumps always taken, halt blocks both
   function automatic logic expectPcSel();
      logic [OPCODE_W-1:0] op;
      logic [DATA_W-1:0]   rs;
      logic                taken;
      op = instr[OPCODE_MSB:OPCODE_LSB];
      rs = expectRead(instr[RS_MSB:RS_LSB]);
      taken = 1'b0;
      if (op[4:2] == 3'b011) begin
         case (op[1:0])
            2'b00:   taken = (rs == 16'h0000);
            2'b01:   taken = (rs != 16'h0000);
            2'b10:   taken = rs[15];
            default: taken = !rs[15];
         endcase
      end
      if ((op == opJ) || (op == opJr) || (op == opJal) || (op == opJalr)) begin
         taken = 1'b1;
      end
      return taken && !halt;
   endfunction

   task automatic checkValue(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("mismatch %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   // Checks the settled outputs, commits the model and moves to the next falling edge
   task automatic finishCycle();
      logic                  en;
      logic [REG_ADDR_W-1:0] wa;
      logic [DATA_W-1:0]     wd;
      #1;
      checkValue("reg1Data", reg1Data, expectRead(instr[RS_MSB:RS_LSB]));
      checkValue("reg2Data", reg2Data, expectRead(instr[RT_MSB:RT_LSB]));
      checkValue("pcSel", {15'd0, pcSel}, {15'd0, expectPcSel()});
      plannedWrite(en, wa, wd);
      if (en) begin
         model[wa] = wd;
      end
      shadow = {shadow[1:0], isLinkJump()};
      @(negedge clk);
   endtask

   task automatic setIdle();
      wbEn = 1'b0;
      lbi  = 1'b0;
      link = 1'b0;
      halt = 1'b0;
   endtask

   task automatic readAll();
      for (int k = 0; k < REG_COUNT; k++) begin
         instr = makeInstr(OP_ALU, 3'(k), 3'(REG_COUNT - 1 - k));  // Both ports sweep
         finishCycle();
      end
   endtask

   task automatic waitResetRelease();
      int cycles;
      cycles = 0;
      while ((rstN !== 1'b1) && (cycles < 40)) begin
         @(negedge clk);
         cycles++;
      end
      if (rstN !== 1'b1) begin
         $display("reset was never released");
         errors++;
      end
   endtask

   // Hard limit on simulated time
   initial begin
      #20000;
      $display("simulation did not finish within its time limit");
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      int                    i;
      logic [REG_ADDR_W-1:0] addr;
      logic [DATA_W-1:0]     value;
      rngState = 32'd24458;
      checks = 0;
      errors = 0;
      shadow = 3'b000;
      for (i = 0; i < REG_COUNT; i++) begin
         model[i] = '0;
      end
      instr = makeInstr(OP_ALU, 3'd0, 3'd0);
      imm = '0;
      writeback = '0;
      pcNow = '0;
      wbAddr = '0;
      setIdle();
      waitResetRelease();

      // Registers come out of reset as zero, then random writebacks
      readAll();
      for (i = 0; i < 32; i++) begin
         wbEn = 1'b1;
         wbAddr = rand3();
         writeback = rand16();
         instr = makeInstr(OP_ALU, rand3(), rand3());
         finishCycle();
      end
      setIdle();
      readAll();

      // Rs on the address being written shows the new data at once
      for (i = 0; i < REG_COUNT; i++) begin
         wbEn = 1'b1;
         wbAddr = 3'(i);
         writeback = rand16();
         instr = makeInstr(OP_ALU, 3'(i), rand3());
         finishCycle();
      end

      // Source selection, lbi then link then both
      imm = rand16();
      writeback = rand16();
      pcNow = rand16();
      wbAddr = 3'd2;
      lbi = 1'b1;
      instr = makeInstr(OP_ALU, 3'd2, 3'd3);
      finishCycle();
      lbi = 1'b0;
      link = 1'b1;
      wbAddr = 3'd3;
      finishCycle();
      lbi = 1'b1;  // Link must still win
      wbAddr = 3'd4;
      pcNow = rand16();
      instr = makeInstr(OP_ALU, 3'd4, 3'd2);
      finishCycle();
      setIdle();
      readAll();

      // Jump and link writes r7 in decode and masks its own late writeback
      for (i = 0; i < 2; i++) begin
         pcNow = rand16();
         instr = makeInstr((i == 0) ? opJal : opJalr, LINK_REG, rand3());
         finishCycle();
         instr = makeInstr(OP_ALU, LINK_REG, 3'd0);
         finishCycle();
         finishCycle();
         wbEn = 1'b1;
         wbAddr = LINK_REG;
         writeback = rand16();
         finishCycle();  // Three cycles on, this write is dropped
         writeback = rand16();
         finishCycle();  // One later it goes through
         wbEn = 1'b0;
         finishCycle();
      end

      // Conditional branches on zero, positive and negative operands
      for (i = 0; i < 24; i++) begin
         addr = rand3();
         value = rand16();
         case ((i / 4) % 3)
            0:       value = 16'h0000;
            1:       value = {1'b0, value[14:1], 1'b1};  // Positive and non-zero
            default: value[15] = 1'b1;                   // Negative
         endcase
         wbEn = 1'b1;
         wbAddr = addr;
         writeback = value;
         instr = makeInstr(OP_ALU, addr, rand3());
         finishCycle();
         wbEn = 1'b0;
         instr = makeInstr({3'b011, 2'(i)}, addr, rand3());  // Cycles through all four conditions
         finishCycle();
      end

      // Unconditional jumps, then every redirecting opcode under halt
      for (i = 0; i < 4; i++) begin
         pcNow = rand16();
         instr = makeInstr({3'b001, 2'(i)}, rand3(), rand3());
         finishCycle();
      end
      halt = 1'b1;
      for (i = 0; i < 8; i++) begin
         instr = makeInstr({1'b0, 1'(i >> 2), 1'b1, 2'(i)}, rand3(), rand3());  // Jumps, then branches
         finishCycle();
      end

      // Halted jump and link leaves r7 alone and sets no shadow
      pcNow = rand16();
      instr = makeInstr(opJal, LINK_REG, LINK_REG);
      finishCycle();
      halt = 1'b0;
      instr = makeInstr(OP_ALU, LINK_REG, 3'd0);
      finishCycle();
      finishCycle();
      wbEn = 1'b1;
      wbAddr = LINK_REG;
      writeback = rand16();
      finishCycle();
      setIdle();
      finishCycle();

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// ==== sources.f ====
rtl/isaPkg.sv
rtl/datapathPkg.sv
rtl/regPortIf.sv
rtl/regFile.sv
rtl/branchResolve.sv
rtl/linkTracker.sv
rtl/decodeStage.sv
tb/tbClock.sv
tb/decodeStageTb.sv

// ==== Makefile ====
# Verilator build and run of the decode stage testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	rm -rf obj_dir sim.log
	verilator --binary --timing --assert --top-module decodeStageTb -f sources.f -o simv
	./obj_dir/simv > sim.log 2>&1 || true
	cat sim.log
	grep -q "^TEST PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
